// File: logic/cpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU package
// Widths, enums and packed records shared by the
// fetch unit, instruction queue and execute unit
// of the cut-down 6502-style core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpu_pkg;

    localparam int ADDR_W = 16;                 // Program address width
    localparam int DATA_W = 8;                  // Data path width
    localparam int ZP_W   = 8;                  // Zero-page address width

    localparam int QUEUE_DEPTH_DEFAULT = 4;     // Decoded instructions in flight

    // Instruction kinds that survive decode
    typedef enum logic [4:0] {
        OP_LOAD,                                // LDA/LDX/LDY #imm
        OP_ADC,
        OP_SBC,
        OP_AND,
        OP_ORA,
        OP_EOR,
        OP_CMP,
        OP_ASL,                                 // Accumulator shifts
        OP_LSR,
        OP_ROL,
        OP_ROR,
        OP_INC,                                 // INX/INY
        OP_DEC,                                 // DEX/DEY
        OP_XFER,                                // TAX/TAY/TXA/TYA
        OP_CLC,
        OP_SEC,
        OP_STORE,                               // STA/STX/STY zp
        OP_NOP                                  // Anything else
    } op_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,                                // a + ~b + ci
        ALU_AND,
        ALU_OR,
        ALU_EOR,
        ALU_SHL,                                // ci shifted into bit 0
        ALU_SHR                                 // ci shifted into bit 7
    } alu_op_e;

    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y
    } reg_sel_e;

    typedef struct packed {
        op_e               op;
        reg_sel_e          src;                 // Register read
        reg_sel_e          dst;                 // Register written
        logic [DATA_W-1:0] operand;             // Immediate or zp address
    } instr_t;

    typedef struct packed {
        logic [ZP_W-1:0]   addr;
        logic [DATA_W-1:0] data;
    } zp_write_t;

endpackage

// File: logic/alu8.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8-bit ALU
// Add, subtract, logic ops and one-bit shifts
// with carry, overflow, zero and negative out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu8 (
    input  cpu_pkg::alu_op_e           op,
    input  logic [cpu_pkg::DATA_W-1:0] a,
    input  logic [cpu_pkg::DATA_W-1:0] b,
    input  logic                       ci,
    output logic [cpu_pkg::DATA_W-1:0] result,
    output logic                       co,
    output logic                       v,
    output logic                       z,
    output logic                       n
);
    import cpu_pkg::*;

    localparam int MSB = DATA_W - 1;

    logic [DATA_W-1:0] b_in;                    // b, inverted for SUB
    logic [DATA_W:0]   sum;                     // Carry in top bit

    assign b_in = (op == ALU_SUB) ? ~b : b;
    assign sum  = {1'b0, a} + {1'b0, b_in} + {{DATA_W{1'b0}}, ci};

    always_comb begin
        result = '0;
        co     = 1'b0;
        v      = 1'b0;
        case (op)
            ALU_ADD, ALU_SUB: begin
                result = sum[DATA_W-1:0];
                co     = sum[DATA_W];           // No-borrow for SUB
                v      = (a[MSB] == b_in[MSB]) && (result[MSB] != a[MSB]);
            end
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_EOR: result = a ^ b;
            ALU_SHL: begin
                result = {a[MSB-1:0], ci};
                co     = a[MSB];                // Bit shifted out
            end
            ALU_SHR: begin
                result = {ci, a[MSB:1]};
                co     = a[0];
            end
            default: result = '0;
        endcase
    end

    assign z = (result == '0);
    assign n = result[MSB];

endmodule

// File: logic/fetch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit
// Reads program bytes, pairs opcodes with operands
// and pushes decoded instructions into the queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fetch_unit (
    input  logic                       clk,
    input  logic                       reset,
    output logic [cpu_pkg::ADDR_W-1:0] rom_addr,
    output logic                       rom_req,
    input  logic [cpu_pkg::DATA_W-1:0] rom_data,
    input  logic                       rom_rdy,
    output logic                       push,
    output cpu_pkg::instr_t            push_data,
    input  logic                       full
);
    import cpu_pkg::*;

    logic [ADDR_W-1:0] pc;                      // Next program byte
    logic              phase;                   // Opcode waiting for operand
    logic              accept;                  // Program read completes
    instr_t            held;                    // Decoded opcode of a 2-byte instr
    instr_t            dec;

    // 6502 opcode map, kept subset only
    function automatic instr_t decode(input logic [DATA_W-1:0] opc);
        instr_t d;
        d = '{OP_NOP, REG_A, REG_A, '0};
        case (opc)
            8'hA9: d = '{OP_LOAD, REG_A, REG_A, '0};
            8'hA2: d = '{OP_LOAD, REG_A, REG_X, '0};
            8'hA0: d = '{OP_LOAD, REG_A, REG_Y, '0};
            8'h69: d = '{OP_ADC, REG_A, REG_A, '0};
            8'hE9: d = '{OP_SBC, REG_A, REG_A, '0};
            8'h29: d = '{OP_AND, REG_A, REG_A, '0};
            8'h09: d = '{OP_ORA, REG_A, REG_A, '0};
            8'h49: d = '{OP_EOR, REG_A, REG_A, '0};
            8'hC9: d = '{OP_CMP, REG_A, REG_A, '0};
            8'h0A: d = '{OP_ASL, REG_A, REG_A, '0};
            8'h4A: d = '{OP_LSR, REG_A, REG_A, '0};
            8'h2A: d = '{OP_ROL, REG_A, REG_A, '0};
            8'h6A: d = '{OP_ROR, REG_A, REG_A, '0};
            8'hE8: d = '{OP_INC, REG_X, REG_X, '0};    // INX
            8'hC8: d = '{OP_INC, REG_Y, REG_Y, '0};    // INY
            8'hCA: d = '{OP_DEC, REG_X, REG_X, '0};    // DEX
            8'h88: d = '{OP_DEC, REG_Y, REG_Y, '0};    // DEY
            8'hAA: d = '{OP_XFER, REG_A, REG_X, '0};   // TAX
            8'hA8: d = '{OP_XFER, REG_A, REG_Y, '0};   // TAY
            8'h8A: d = '{OP_XFER, REG_X, REG_A, '0};   // TXA
            8'h98: d = '{OP_XFER, REG_Y, REG_A, '0};   // TYA
            8'h18: d = '{OP_CLC, REG_A, REG_A, '0};
            8'h38: d = '{OP_SEC, REG_A, REG_A, '0};
            8'h85: d = '{OP_STORE, REG_A, REG_A, '0};  // STA zp
            8'h86: d = '{OP_STORE, REG_X, REG_X, '0};  // STX zp
            8'h84: d = '{OP_STORE, REG_Y, REG_Y, '0};  // STY zp
            default: d = '{OP_NOP, REG_A, REG_A, '0};
        endcase
        return d;
    endfunction

    // Kept immediates plus zp stores carry an operand byte
    function automatic logic two_byte(input logic [DATA_W-1:0] opc);
        return opc inside {8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29,
                           8'h09, 8'h49, 8'hC9, 8'h85, 8'h86, 8'h84};
    endfunction

    assign rom_req  = ~full;                    // Only read what can be pushed
    assign rom_addr = pc;
    assign accept   = rom_req & rom_rdy;
    assign dec      = decode(rom_data);
    assign push     = accept & (phase | ~two_byte(rom_data));

    always_comb begin
        push_data = phase ? held : dec;
        if (phase)
            push_data.operand = rom_data;       // Second byte completes entry
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= '0;
            phase <= 1'b0;
        end else if (accept) begin
            pc    <= pc + 1'b1;
            phase <= ~phase & two_byte(rom_data);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !phase)
            held <= dec;                        // Park opcode until operand
    end

    // Pending read keeps request and address until rom_rdy
    a_rom_hold: assert property (@(posedge clk) disable iff (reset)
        rom_req && !rom_rdy |=> rom_req && $stable(rom_addr));

endmodule

// File: logic/instr_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction queue
// Circular FIFO of decoded instructions between
// the fetch and execute units
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module instr_queue #(
    parameter int DEPTH = cpu_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            push,
    input  cpu_pkg::instr_t push_data,
    output logic            full,
    input  logic            pop,
    output cpu_pkg::instr_t pop_data,
    output logic            empty
);
    import cpu_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    instr_t            mem [DEPTH];             // Entry storage
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;                   // Entries held

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];              // Head visible the cycle after push

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;          // Both at once keeps count
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    a_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);
    a_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// File: logic/execute_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute unit
// A/X/Y register file, C/Z/V/N flags and ALU;
// retires one queue entry per cycle and drives
// the zero-page write port for stores
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module execute_unit (
    input  logic               clk,
    input  logic               reset,
    output logic               pop,
    input  cpu_pkg::instr_t    pop_data,
    input  logic               empty,
    output logic               wr_valid,
    output cpu_pkg::zp_write_t wr,
    input  logic               wr_ready
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] regs [3];                // Indexed by reg_sel_e
    logic              c_flag;
    logic              z_flag;
    logic              v_flag;
    logic              n_flag;

    logic [DATA_W-1:0] src_val;                 // Source register of head entry
    alu_op_e           alu_op;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic              alu_ci;
    logic [DATA_W-1:0] alu_result;
    logic              alu_co;
    logic              alu_v;
    logic              alu_z;
    logic              alu_n;
    logic              wr_reg;                  // Result goes to dst
    logic              upd_zn;
    logic              upd_c;
    logic              upd_v;
    logic              is_store;

    assign src_val  = regs[pop_data.src];
    assign is_store = (pop_data.op == OP_STORE);
    assign wr_valid = ~empty & is_store;
    assign pop      = ~empty & (~is_store | wr_ready);  // Stores wait for the port
    assign wr.addr  = pop_data.operand;
    assign wr.data  = src_val;

    // Op to ALU control
    always_comb begin
        alu_op = ALU_OR;
        alu_a  = src_val;
        alu_b  = pop_data.operand;
        alu_ci = 1'b0;
        wr_reg = 1'b1;
        upd_c  = 1'b0;
        upd_v  = 1'b0;
        case (pop_data.op)
            OP_LOAD: alu_a = '0;                // 0 | imm
            OP_ADC: begin
                alu_op = ALU_ADD;
                alu_ci = c_flag;
                upd_c  = 1'b1;
                upd_v  = 1'b1;
            end
            OP_SBC: begin
                alu_op = ALU_SUB;
                alu_ci = c_flag;                // C set means no borrow
                upd_c  = 1'b1;
                upd_v  = 1'b1;
            end
            OP_AND: alu_op = ALU_AND;
            OP_ORA: alu_op = ALU_OR;
            OP_EOR: alu_op = ALU_EOR;
            OP_CMP: begin
                alu_op = ALU_SUB;
                alu_ci = 1'b1;
                wr_reg = 1'b0;                  // Flags only
                upd_c  = 1'b1;
            end
            OP_ASL, OP_ROL: begin
                alu_op = ALU_SHL;
                alu_ci = (pop_data.op == OP_ROL) & c_flag;
                upd_c  = 1'b1;
            end
            OP_LSR, OP_ROR: begin
                alu_op = ALU_SHR;
                alu_ci = (pop_data.op == OP_ROR) & c_flag;
                upd_c  = 1'b1;
            end
            OP_INC: begin
                alu_op = ALU_ADD;
                alu_b  = DATA_W'(1);
            end
            OP_DEC: begin
                alu_op = ALU_SUB;
                alu_b  = DATA_W'(1);
                alu_ci = 1'b1;                  // Plain subtract of 1
            end
            OP_XFER: alu_b = '0;                // src | 0
            default: wr_reg = 1'b0;             // CLC, SEC, STORE, NOP
        endcase
        upd_zn = wr_reg | (pop_data.op == OP_CMP);
    end

    alu8 alu8_inst (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .ci     (alu_ci),
        .result (alu_result),
        .co     (alu_co),
        .v      (alu_v),
        .z      (alu_z),
        .n      (alu_n)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs[REG_A] <= '0;
            regs[REG_X] <= '0;
            regs[REG_Y] <= '0;
        end else if (pop && wr_reg) begin
            regs[pop_data.dst] <= alu_result;   // Retire on pop edge
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            c_flag <= 1'b0;
            z_flag <= 1'b0;
            v_flag <= 1'b0;
            n_flag <= 1'b0;
        end else if (pop) begin
            if (upd_zn) begin
                z_flag <= alu_z;
                n_flag <= alu_n;
            end
            if (upd_c)
                c_flag <= alu_co;
            else if (pop_data.op == OP_CLC)
                c_flag <= 1'b0;
            else if (pop_data.op == OP_SEC)
                c_flag <= 1'b1;
            if (upd_v)
                v_flag <= alu_v;                // Signed overflow of ADC/SBC
        end
    end

    // Store held steady until the port takes it
    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr));

endmodule

// File: logic/cpu_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU core top level
// Fetch unit, instruction queue and execute unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cpu_core #(
    parameter int QUEUE_DEPTH = cpu_pkg::QUEUE_DEPTH_DEFAULT
) (
    input  logic                       clk,
    input  logic                       reset,
    output logic [cpu_pkg::ADDR_W-1:0] rom_addr,
    output logic                       rom_req,
    input  logic [cpu_pkg::DATA_W-1:0] rom_data,
    input  logic                       rom_rdy,
    output logic                       wr_valid,
    output cpu_pkg::zp_write_t         wr,
    input  logic                       wr_ready
);
    import cpu_pkg::*;

    logic   push;
    logic   full;
    logic   pop;
    logic   empty;
    instr_t push_data;                          // Fetch to queue
    instr_t pop_data;                           // Queue head to execute

    fetch_unit fetch_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .rom_addr  (rom_addr),
        .rom_req   (rom_req),
        .rom_data  (rom_data),
        .rom_rdy   (rom_rdy),
        .push      (push),
        .push_data (push_data),
        .full      (full)
    );

    instr_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) instr_queue_inst (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    execute_unit execute_unit_inst (
        .clk      (clk),
        .reset    (reset),
        .pop      (pop),
        .pop_data (pop_data),
        .empty    (empty),
        .wr_valid (wr_valid),
        .wr       (wr),
        .wr_ready (wr_ready)
    );

endmodule

// File: bench/cpu_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store checker
// ISA model of the kept instructions walks the ROM
// image; accepted stores are compared in order,
// program reads checked for sequence and hold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cpu_checker #(
    parameter int ROM_SIZE = 256
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [7:0]                 rom [ROM_SIZE],
    input  logic [cpu_pkg::ADDR_W-1:0] rom_addr,
    input  logic                       rom_req,
    input  logic                       rom_rdy,
    input  logic                       wr_valid,
    input  cpu_pkg::zp_write_t         wr,
    input  logic                       wr_ready,
    output int                         err_count,
    output int                         checked,
    output logic                       done
);
    import cpu_pkg::*;

    zp_write_t         exp_q [$];               // Expected stores, program order
    zp_write_t         exp_st;
    logic              ref_built = 1'b0;
    int                exp_count = 0;
    int                errs = 0;
    int                seen = 0;
    logic [ADDR_W-1:0] next_addr;               // Straight-line read address
    logic              rd_pending;              // Read waiting on rom_rdy

    assign err_count = errs;
    assign checked   = seen;
    assign done      = ref_built && (seen >= exp_count);

    // Only A, X, Y and C reach a stored value
    function automatic void run_reference();
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] opc;
        logic [7:0] imm;
        logic       c;
        int         tot;
        int         pc;
        zp_write_t  st;
        a  = 8'h00;
        x  = 8'h00;
        y  = 8'h00;
        c  = 1'b0;
        pc = 0;
        exp_q.delete();
        while (pc < ROM_SIZE) begin
            opc = rom[pc];
            imm = (pc + 1 < ROM_SIZE) ? rom[pc + 1] : 8'hEA;
            pc  = pc + 1;
            case (opc)
                8'hA9: begin a = imm; pc++; end
                8'hA2: begin x = imm; pc++; end
                8'hA0: begin y = imm; pc++; end
                8'h69: begin                    // ADC, carry out above 255
                    tot = int'(a) + int'(imm) + int'(c);
                    a   = tot[7:0];
                    c   = (tot > 255);
                    pc++;
                end
                8'hE9: begin                    // SBC, C clear borrows one
                    tot = int'(a) - int'(imm) - (c ? 0 : 1);
                    a   = tot[7:0];
                    c   = (tot >= 0);
                    pc++;
                end
                8'h29: begin a = a & imm; pc++; end
                8'h09: begin a = a | imm; pc++; end
                8'h49: begin a = a ^ imm; pc++; end
                8'hC9: begin c = (a >= imm); pc++; end
                8'h0A: begin c = a[7]; a = a << 1; end
                8'h4A: begin c = a[0]; a = a >> 1; end
                8'h2A: {c, a} = {a, c};         // ROL
                8'h6A: {a, c} = {c, a};         // ROR
                8'hE8: x = x + 8'd1;
                8'hC8: y = y + 8'd1;
                8'hCA: x = x - 8'd1;
                8'h88: y = y - 8'd1;
                8'hAA: x = a;
                8'hA8: y = a;
                8'h8A: a = x;
                8'h98: a = y;
                8'h18: c = 1'b0;
                8'h38: c = 1'b1;
                8'h85, 8'h86, 8'h84: begin
                    st.addr = imm;
                    st.data = (opc == 8'h85) ? a : (opc == 8'h86) ? x : y;
                    exp_q.push_back(st);
                    pc++;
                end
                default: ;                      // One-byte NOP
            endcase
        end
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            next_addr  = '0;
            rd_pending = 1'b0;
        end else begin
            if (!ref_built) begin
                run_reference();
                exp_count = exp_q.size();
                ref_built = 1'b1;
            end
            if (rd_pending && rom_req !== 1'b1) begin
                $display("Error at %0t: rom_req expected 1, got %b", $time, rom_req);
                errs++;
            end
            if (rom_req && rom_addr !== next_addr) begin
                $display("Error at %0t: rom_addr expected %h, got %h",
                         $time, next_addr, rom_addr);
                errs++;
            end
            if (rom_req && rom_rdy)
                next_addr = next_addr + 1'b1;   // One byte per accepted read
            rd_pending = rom_req && !rom_rdy;
            if (wr_valid && wr_ready) begin
                if (seen >= exp_count) begin
                    $display("Unexpected extra store at %0t to address %h", $time, wr.addr);
                    errs++;
                end else begin
                    exp_st = exp_q[seen];
                    if (wr.addr !== exp_st.addr) begin
                        $display("Error at %0t: wr.addr expected %h, got %h",
                                 $time, exp_st.addr, wr.addr);
                        errs++;
                    end
                    if (wr.data !== exp_st.data) begin
                        $display("Error at %0t: wr.data expected %h, got %h",
                                 $time, exp_st.data, wr.data);
                        errs++;
                    end
                end
                seen++;                         // Store number in program order
            end
        end
    end

endmodule

// File: bench/cpu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU core testbench
// Random straight-line program in a ROM model,
// random program-bus and write-port stalls;
// stores are checked by cpu_checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int ROM_SIZE       = 256;
    localparam int PROG_LEN       = 200;        // Random part, final stores follow
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk      = 1'b0;
    logic              reset    = 1'b1;
    logic [ADDR_W-1:0] rom_addr;
    logic              rom_req;
    logic [DATA_W-1:0] rom_data = 8'hEA;
    logic              rom_rdy  = 1'b0;
    logic              wr_valid;
    zp_write_t         wr;
    logic              wr_ready = 1'b0;
    logic              all_stored;              // Checker saw every expected store
    int                check_errors;
    int                stores_checked;
    int                errors = 0;
    int                ready_left = 0;          // Cycles left in wr_ready stretch
    integer            seed = 32'h8635_07bb;
    logic [7:0]        rom [ROM_SIZE];

    // Opcode pools for the random program
    logic [7:0] imm_ops [9] = '{8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9,
                                8'h29, 8'h09, 8'h49, 8'hC9};
    logic [7:0] one_ops [18] = '{8'h0A, 8'h4A, 8'h2A, 8'h6A, 8'hE8, 8'hC8,
                                 8'hCA, 8'h88, 8'hAA, 8'hA8, 8'h8A, 8'h98,
                                 8'h18, 8'h38, 8'h02, 8'hB5, 8'h6C, 8'hFF};
    logic [7:0] st_ops [3] = '{8'h85, 8'h86, 8'h84};

    always #50 clk = ~clk;                      // 100 ns period

    cpu_core #(
        .QUEUE_DEPTH (QUEUE_DEPTH_DEFAULT)
    ) cpu_core_inst (
        .clk      (clk),
        .reset    (reset),
        .rom_addr (rom_addr),
        .rom_req  (rom_req),
        .rom_data (rom_data),
        .rom_rdy  (rom_rdy),
        .wr_valid (wr_valid),
        .wr       (wr),
        .wr_ready (wr_ready)
    );

    cpu_checker #(
        .ROM_SIZE (ROM_SIZE)
    ) cpu_checker_inst (
        .clk       (clk),
        .reset     (reset),
        .rom       (rom),
        .rom_addr  (rom_addr),
        .rom_req   (rom_req),
        .rom_rdy   (rom_rdy),
        .wr_valid  (wr_valid),
        .wr        (wr),
        .wr_ready  (wr_ready),
        .err_count (check_errors),
        .checked   (stores_checked),
        .done      (all_stored)
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Random kept instructions, a store every few, then STA/STX/STY
    task automatic build_program();
        int pos;
        int gap;
        for (int k = 0; k < ROM_SIZE; k++)
            rom[k] = 8'hEA;                     // NOP tail
        pos = 0;
        gap = 1 + rand_below(4);
        while (pos < PROG_LEN) begin
            if (gap == 0) begin
                rom[pos]     = st_ops[rand_below(3)];
                rom[pos + 1] = 8'(rand_below(256));
                pos          = pos + 2;
                gap          = 1 + rand_below(4);
            end else if (rand_below(2) == 0) begin
                rom[pos]     = imm_ops[rand_below(9)];
                rom[pos + 1] = 8'(rand_below(256));
                pos          = pos + 2;
                gap          = gap - 1;
            end else begin
                rom[pos] = one_ops[rand_below(18)];
                pos      = pos + 1;
                gap      = gap - 1;
            end
        end
        rom[pos]     = 8'h85;                   // STA $F0
        rom[pos + 1] = 8'hF0;
        rom[pos + 2] = 8'h86;                   // STX $F1
        rom[pos + 3] = 8'hF1;
        rom[pos + 4] = 8'h84;                   // STY $F2
        rom[pos + 5] = 8'hF2;
    endtask

    task automatic wait_for_stores();
        int cycles;
        cycles = 0;
        while (!all_stored && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!all_stored) begin
            $display("Timeout: only %0d stores arrived within %0d cycles",
                     stores_checked, TIMEOUT_CYCLES);
            errors++;
        end
    endtask

    // ROM read data, ready stretches
    always @(negedge clk) begin
        rom_rdy  <= (rand_below(4) != 0);
        rom_data <= (rom_addr < ROM_SIZE) ? rom[rom_addr[7:0]] : 8'hEA;
        if (ready_left == 0) begin
            if (rand_below(4) == 0) begin
                wr_ready   <= 1'b0;             // Long back-pressure
                ready_left <= 4 + rand_below(20);
            end else begin
                wr_ready   <= 1'b1;
                ready_left <= 1 + rand_below(12);
            end
        end else begin
            ready_left <= ready_left - 1;
        end
    end

    initial begin
        build_program();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_for_stores();
        repeat (20) @(negedge clk);             // Room for any stray store
        errors = errors + check_errors;
        $display("Stores checked: %0d, errors: %0d", stores_checked, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: vlog.f
logic/cpu_pkg.sv
logic/alu8.sv
logic/fetch_unit.sv
logic/instr_queue.sv
logic/execute_unit.sv
logic/cpu_core.sv
bench/cpu_checker.sv
bench/cpu_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run cpu_tb, check sim.log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f vlog.f -o cpu_sim
	./obj_dir/cpu_sim | tee sim.log
	@if grep -q "Finished with errors" sim.log; then echo "TEST FAILED"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "TEST DID NOT COMPLETE"; exit 1)
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir sim.log
